// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_top
FILELIST  := compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+include
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/bypass_if.sv
rtl/reg_file.sv
rtl/operand_bypass.sv
rtl/issue_stage.sv
rtl/alu_stage.sv
rtl/rv_pipe_top.sv
dv/tb_clkgen.sv
dv/tb_top.sv

// File: dv/alu_patterns.txt
// op rd rs1 rs2 imm expected, all hex
// op 0 ADD 1 SUB 2 AND 3 OR 4 XOR 5 SLL 6 SRL 7 SRA 8 ADDI, rd 00 never retires
8 01 00 00 0000000000000005 0000000000000005
8 02 00 00 fffffffffffffff0 fffffffffffffff0
8 03 00 00 0123456789abcdef 0123456789abcdef
8 04 00 00 0000000000000024 0000000000000024
8 05 00 00 8000000000000001 8000000000000001
8 06 00 00 00000000000000ff 00000000000000ff
0 07 01 03 0000000000000000 0123456789abcdf4
1 08 01 02 0000000000000000 0000000000000015
2 09 03 06 0000000000000000 00000000000000ef
3 0a 03 02 0000000000000000 ffffffffffffffff
4 0b 03 06 0000000000000000 0123456789abcd10
5 0c 01 04 0000000000000000 0000005000000000
6 0d 05 04 0000000000000000 0000000008000000
7 0e 05 04 0000000000000000 fffffffff8000000
8 0f 06 00 ffffffffffffff01 0000000000000000
8 10 00 00 0000000000000010 0000000000000010
0 11 10 01 0000000000000000 0000000000000015
1 12 01 11 0000000000000000 fffffffffffffff0
4 13 12 12 0000000000000000 0000000000000000
3 14 13 12 0000000000000000 fffffffffffffff0
8 15 00 00 0000000000000001 0000000000000001
8 15 15 00 0000000000000002 0000000000000003
8 15 15 00 0000000000000004 0000000000000007
0 15 15 15 0000000000000000 000000000000000e
5 16 15 01 0000000000000000 00000000000001c0
1 17 15 16 0000000000000000 fffffffffffffe4e
7 18 17 01 0000000000000000 fffffffffffffff2
6 19 17 04 0000000000000000 000000000fffffff
8 00 00 00 0000000000000077 0000000000000000
0 1a 00 01 0000000000000000 0000000000000005
0 00 01 01 0000000000000000 0000000000000000
3 1b 00 00 0000000000000000 0000000000000000
8 00 03 00 0000000000000001 0000000000000000
8 1c 00 00 000000000000002a 000000000000002a
1 1d 1c 1a 0000000000000000 0000000000000025
2 1e 1d 1c 0000000000000000 0000000000000020
5 1f 1e 1d 0000000000000000 0000040000000000
4 1f 1f 03 0000000000000000 0123416789abcdef
8 01 1f 00 ffffffffffffffff 0123416789abcdee
0 02 01 01 0000000000000000 024682cf13579bdc
1 03 02 01 0000000000000000 0123416789abcdee

// File: dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;   // 8 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;   // release away from the active edge
    end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/1ps
`include "rvseed_params.svh"

module tb_top;

    import rv_isa_pkg::*;

    localparam int RESET_CYCLES = 10;

    typedef struct packed {
        logic [3:0]                 op;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`XLEN-1:0]           imm;
        logic [`XLEN-1:0]           res;
    } row_t;

    typedef struct packed {
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`XLEN-1:0]           data;
        int                         cycle;   // cyc value while wb_valid is due
    } wb_exp_t;

    logic                       clk;
    logic                       arst_n;
    logic                       in_valid;
    alu_op_e                    in_op;
    logic [`REG_ADDR_WIDTH-1:0] in_rd;
    logic [`REG_ADDR_WIDTH-1:0] in_rs1;
    logic [`REG_ADDR_WIDTH-1:0] in_rs2;
    logic [`XLEN-1:0]           in_imm;
    logic                       wb_valid;
    logic [`REG_ADDR_WIDTH-1:0] wb_rd;
    logic [`XLEN-1:0]           wb_data;

    row_t        rows [$];
    wb_exp_t     exp_q [$];
    int          cyc = 0;
    int          timeout_cycles = 0;
    int unsigned lcg_state = 40089;

    tb_clkgen #(.RESET_CYCLES(RESET_CYCLES)) u_clkgen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv_pipe_top dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_rd    (in_rd),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_imm   (in_imm),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic load_patterns();
        int                         fd;
        int                         n;
        string                      line;
        logic [3:0]                 op;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`XLEN-1:0]           imm;
        logic [`XLEN-1:0]           res;
        fd = $fopen("dv/alu_patterns.txt", "r");
        assert (fd != 0) else stop_run("could not open dv/alu_patterns.txt");
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h", op, rd, rs1, rs2, imm, res);
            if (n == 6) begin   // comment lines do not scan
                rows.push_back('{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm, res: res});
            end
        end
        $fclose(fd);
        assert (rows.size() > 0) else stop_run("pattern file holds no rows");
    endtask

    task automatic drive_row(input row_t r);
        wb_exp_t e;
        in_valid <= 1'b1;
        in_op    <= alu_op_e'(r.op);
        in_rd    <= r.rd;
        in_rs1   <= r.rs1;
        in_rs2   <= r.rs2;
        in_imm   <= r.imm;
        if (r.rd != '0) begin
            // sampled next edge, then three more edges to writeback
            e.rd    = r.rd;
            e.data  = r.res;
            e.cycle = cyc + 4;
            exp_q.push_back(e);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cycle count and timeout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            stop_run($sformatf("run timed out after %0d cycles", cyc));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback checks, mid cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        wb_exp_t e;
        if (!arst_n) begin
            assert (!wb_valid) else stop_run($sformatf("Fail @ %0t: wb_valid in reset", $time));
        end else if (wb_valid) begin
            assert (exp_q.size() != 0)
                else stop_run($sformatf("Fail @ %0t: writeback of x%0d not expected",
                                        $time, wb_rd));
            e = exp_q.pop_front();
            assert (cyc == e.cycle)
                else stop_run($sformatf("Fail @ %0t: x%0d retired at cycle %0d, expected %0d",
                                        $time, e.rd, cyc, e.cycle));
            assert (wb_rd == e.rd)
                else stop_run($sformatf("Fail @ %0t: wb_rd is x%0d, expected x%0d",
                                        $time, wb_rd, e.rd));
            assert (wb_data == e.data)
                else stop_run($sformatf("Fail @ %0t: x%0d data %h, expected %h",
                                        $time, e.rd, wb_data, e.data));
        end else if (exp_q.size() != 0) begin
            assert (exp_q[0].cycle != cyc)
                else stop_run($sformatf("Fail @ %0t: writeback of x%0d missing",
                                        $time, exp_q[0].rd));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int gap;
        in_valid <= 1'b0;
        in_op    <= ADD;
        in_rd    <= '0;
        in_rs1   <= '0;
        in_rs2   <= '0;
        in_imm   <= '0;
        load_patterns();
        timeout_cycles = rows.size() * 4 + RESET_CYCLES + 20;
        @(posedge arst_n);
        foreach (rows[i]) begin
            @(posedge clk);
            drive_row(rows[i]);
            gap = int'(lcg_next() % 4);   // shifts which path a dependency takes
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);   // nothing retires after the last one
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: include/rvseed_params.svh
`ifndef RVSEED_PARAMS_SVH
`define RVSEED_PARAMS_SVH

// datapath width
`define XLEN 64

// register addressing
`define REG_ADDR_WIDTH 5
`define NUM_REGS 32

`endif

// File: rtl/alu_stage.sv
`timescale 1ns/1ps
`include "rvseed_params.svh"

module alu_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  rv_pipe_pkg::ex_ctrl_t      ex_ctrl,
    bypass_if.src                      byp,
    output logic                       wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [`XLEN-1:0]           wb_data
);

    import rv_isa_pkg::*;

    logic [SHAMT_W-1:0]         shamt;
    logic [`XLEN-1:0]           alu_res;

    // EX/MEM
    logic                       mem_wr_q;
    logic [`REG_ADDR_WIDTH-1:0] mem_rd_q;
    logic [`XLEN-1:0]           mem_res_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign shamt = ex_ctrl.b[SHAMT_W-1:0];

    always_comb begin
        case (ex_ctrl.op)
            ADD, ADDI: alu_res = ex_ctrl.a + ex_ctrl.b;
            SUB:       alu_res = ex_ctrl.a - ex_ctrl.b;
            AND:       alu_res = ex_ctrl.a & ex_ctrl.b;
            OR:        alu_res = ex_ctrl.a | ex_ctrl.b;
            XOR:       alu_res = ex_ctrl.a ^ ex_ctrl.b;
            SLL:       alu_res = ex_ctrl.a << shamt;
            SRL:       alu_res = ex_ctrl.a >> shamt;
            SRA:       alu_res = $signed(ex_ctrl.a) >>> shamt;
            default:   alu_res = '0;
        endcase
    end

    // back to operand read, one instruction behind issue
    assign byp.ex_wr  = ex_ctrl.wr;
    assign byp.ex_rd  = ex_ctrl.rd;
    assign byp.ex_res = alu_res;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wr_q <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            mem_wr_q <= ex_ctrl.wr;
            wb_valid <= mem_wr_q;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd_q  <= ex_ctrl.rd;
        mem_res_q <= alu_res;
        wb_rd     <= mem_rd_q;
        wb_data   <= mem_res_q;
    end

    // covers instr two behind and writes the RF, so the
    // third one behind already reads the new value
    assign byp.mem_wr  = mem_wr_q;
    assign byp.mem_rd  = mem_rd_q;
    assign byp.mem_res = mem_res_q;

endmodule

// File: rtl/bypass_if.sv
`timescale 1ns/1ps
`include "rvseed_params.svh"

// results travelling back from the ALU stage to operand read
interface bypass_if;

    logic                       ex_wr;
    logic [`REG_ADDR_WIDTH-1:0] ex_rd;
    logic [`XLEN-1:0]           ex_res;  // combinational, instr now in EX

    logic                       mem_wr;
    logic [`REG_ADDR_WIDTH-1:0] mem_rd;
    logic [`XLEN-1:0]           mem_res;

    modport src (
        output ex_wr, ex_rd, ex_res,
        output mem_wr, mem_rd, mem_res
    );

    modport sink (
        input ex_wr, ex_rd, ex_res,
        input mem_wr, mem_rd, mem_res
    );

endinterface

// File: rtl/issue_stage.sv
`timescale 1ns/1ps
`include "rvseed_params.svh"

module issue_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  rv_isa_pkg::alu_op_e        in_op,
    input  logic [`REG_ADDR_WIDTH-1:0] in_rd,
    input  logic [`REG_ADDR_WIDTH-1:0] in_rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] in_rs2,
    input  logic [`XLEN-1:0]           in_imm,
    bypass_if.sink                     byp,
    output rv_pipe_pkg::ex_ctrl_t      ex_ctrl
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [`XLEN-1:0] rf_data1;
    logic [`XLEN-1:0] rf_data2;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    ex_ctrl_t         ctrl_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand read and forwarding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    reg_file u_rf (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (in_rs1),
        .raddr2 (in_rs2),
        .waddr  (byp.mem_rd),   // retiring result
        .wr     (byp.mem_wr),
        .wdata  (byp.mem_res),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2)
    );

    operand_bypass u_bypass (
        .rs1      (in_rs1),
        .rs2      (in_rs2),
        .rf_data1 (rf_data1),
        .rf_data2 (rf_data2),
        .byp      (byp),
        .op1      (op1),
        .op2      (op2)
    );

    always_comb begin
        ctrl_d.wr = in_valid && (in_rd != '0);  // bubbles and x0 writes drop here
        ctrl_d.op = in_op;
        ctrl_d.rd = in_rd;
        ctrl_d.a  = op1;
        ctrl_d.b  = (in_op == ADDI) ? in_imm : op2;
    end

    // ID/EX
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_ctrl <= '0;
        end else begin
            ex_ctrl <= ctrl_d;
        end
    end

endmodule

// File: rtl/operand_bypass.sv
`timescale 1ns/1ps
`include "rvseed_params.svh"

module operand_bypass (
    input  logic [`REG_ADDR_WIDTH-1:0] rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2,
    input  logic [`XLEN-1:0]           rf_data1,
    input  logic [`XLEN-1:0]           rf_data2,
    bypass_if.sink                     byp,
    output logic [`XLEN-1:0]           op1,
    output logic [`XLEN-1:0]           op2
);

    import rv_pipe_pkg::*;

    fwd_sel_e sel1;
    fwd_sel_e sel2;

    // newest producer wins, wr bits never set for x0
    function automatic fwd_sel_e src_of(input logic [`REG_ADDR_WIDTH-1:0] rs);
        fwd_sel_e sel;
        if (byp.ex_wr && (byp.ex_rd == rs)) begin
            sel = FWD_EX;
        end else if (byp.mem_wr && (byp.mem_rd == rs)) begin
            sel = FWD_MEM;
        end else begin
            sel = FWD_RF;
        end
        return sel;
    endfunction

    function automatic logic [`XLEN-1:0] steer(
        input fwd_sel_e         sel,
        input logic [`XLEN-1:0] rf
    );
        logic [`XLEN-1:0] d;
        case (sel)
            FWD_EX:  d = byp.ex_res;
            FWD_MEM: d = byp.mem_res;
            default: d = rf;
        endcase
        return d;
    endfunction

    // operands resolved independently
    always_comb begin
        sel1 = src_of(rs1);
        sel2 = src_of(rs2);
        op1  = steer(sel1, rf_data1);
        op2  = steer(sel2, rf_data2);
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`include "rvseed_params.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr,
    input  logic                       wr,
    input  logic [`XLEN-1:0]           wdata,
    output logic [`XLEN-1:0]           rdata1,
    output logic [`XLEN-1:0]           rdata2
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr) begin   // wr never set for x0
            regs[waddr] <= wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read ports, old value during a same-cycle write
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: rtl/rv_isa_pkg.sv
`include "rvseed_params.svh"

package rv_isa_pkg;

    // low bits of operand b used as shift amount
    localparam int SHAMT_W = $clog2(`XLEN);

    // integer ALU operations, register-register plus one immediate form
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        SLL  = 4'h5,
        SRL  = 4'h6,
        SRA  = 4'h7,
        ADDI = 4'h8   // imm replaces rs2
    } alu_op_e;

endpackage

// File: rtl/rv_pipe_pkg.sv
`include "rvseed_params.svh"

package rv_pipe_pkg;

    // where one operand came from
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_EX  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_e;

    // ID/EX register contents
    typedef struct packed {
        logic                       wr;   // valid and rd != x0
        rv_isa_pkg::alu_op_e        op;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`XLEN-1:0]           a;
        logic [`XLEN-1:0]           b;    // holds imm for ADDI
    } ex_ctrl_t;

endpackage

// File: rtl/rv_pipe_top.sv
`timescale 1ns/1ps
`include "rvseed_params.svh"

module rv_pipe_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  rv_isa_pkg::alu_op_e        in_op,
    input  logic [`REG_ADDR_WIDTH-1:0] in_rd,
    input  logic [`REG_ADDR_WIDTH-1:0] in_rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] in_rs2,
    input  logic [`XLEN-1:0]           in_imm,
    output logic                       wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [`XLEN-1:0]           wb_data
);

    import rv_pipe_pkg::*;

    ex_ctrl_t ex_ctrl;   // ID/EX

    bypass_if byp_if ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    issue_stage u_issue (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_rd    (in_rd),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_imm   (in_imm),
        .byp      (byp_if.sink),
        .ex_ctrl  (ex_ctrl)
    );

    alu_stage u_alu (
        .clk      (clk),
        .arst_n   (arst_n),
        .ex_ctrl  (ex_ctrl),
        .byp      (byp_if.src),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule
